// File: project.f
source/mul_cfg_pkg.sv
source/mul_types_pkg.sv
source/digit_mul_unit.sv
source/digit_sequencer.sv
source/product_accumulator.sv
source/mul_top.sv
sim/mul_props.sv
sim/mul_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the multiplier testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f project.f --top-module mul_tb -o mul_sim

# Keep running after an assertion error so the testbench can report
output=$(./obj_dir/mul_sim +verilator+error+limit+1000 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx 'All tests passed!'; then
	exit 0
else
	exit 1
fi

// File: sim/mul_props.sv
/*
 * Sequencer protocol assertions
 * Bound into digit_sequencer to watch done, busy and the digit command
 */
`timescale 1ns/1ps

module mul_props
	import mul_types_pkg::*;
(
	input logic        clk,
	input logic        rst,
	input seq_state_t  state,
	input digit_cmd_t  cmd,
	input logic        partial_valid,
	input mul_status_t status
);

	// Failure count, read by the testbench at the end of the run
	int fail_cnt = 0;

	done_one_cycle: assert property (@(posedge clk) disable iff (rst)
		status.done |=> !status.done)
		else begin
			fail_cnt++;
			$error("done stayed high for more than one cycle");
		end

	// Done follows the last partial wait with busy already low
	busy_low_at_done: assert property (@(posedge clk) disable iff (rst)
		status.done |-> (!status.busy && $past(state) == ST_WAIT_PARTIAL))
		else begin
			fail_cnt++;
			$error("busy high in the done cycle or done not after a partial wait");
		end

	start_only_busy: assert property (@(posedge clk) disable iff (rst)
		cmd.start |-> status.busy)
		else begin
			fail_cnt++;
			$error("digit start issued while not busy");
		end

	no_start_with_partial: assert property (@(posedge clk) disable iff (rst)
		!(partial_valid && cmd.start))
		else begin
			fail_cnt++;
			$error("partial_valid and digit start in the same cycle");
		end

endmodule

bind digit_sequencer mul_props props0 (
	.clk           (clk),
	.rst           (rst),
	.state         (state),
	.cmd           (cmd),
	.partial_valid (partial_valid),
	.status        (status)
);

// File: sim/mul_tb.sv
/*
 * Testbench for the digit-serial multiplier
 * Table of operand pairs with reference products, latency, ignore and hold checks
 */
`timescale 1ns/1ps

module mul_tb
	import mul_cfg_pkg::*;
	import mul_types_pkg::*;
();

	localparam int A_W = A_WIDTH_DEF;
	localparam int B_W = B_WIDTH_DEF;
	localparam int D_W = DIGIT_WIDTH_DEF;
	localparam int P_W = A_W + B_W;
	localparam int NUM_DIGITS = B_W / D_W;
	localparam int LATENCY = 1 + NUM_DIGITS * (D_W + 2);
	localparam int NUM_DIRECTED = 8;
	localparam int NUM_ROWS = NUM_DIRECTED + 8;
	localparam int TIMEOUT_CYCLES = NUM_ROWS * 120 + 200;
	// Run cycle in which the ignored start is seen by the DUT
	localparam int DECOY_CYCLE = 20;

	typedef struct packed {
		logic [A_W-1:0] a;
		logic [B_W-1:0] b;
		logic           busy_start;
		logic [3:0]     gap;
	} row_t;

	logic           clk;
	logic           rst;
	logic           start;
	logic [A_W-1:0] a;
	logic [B_W-1:0] b;
	logic [P_W-1:0] product;
	mul_status_t    status;

	row_t rows [NUM_ROWS];
	int   seed;
	int   errors;
	int   checks;
	int   cycle_cnt = 0;

	mul_top #(
		.A_WIDTH     (A_W),
		.B_WIDTH     (B_W),
		.DIGIT_WIDTH (D_W)
	) dut0 (
		.clk     (clk),
		.rst     (rst),
		.start   (start),
		.a       (a),
		.b       (b),
		.product (product),
		.status  (status)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Hang guard
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Test failures found");
			$finish;
		end
	end

	function automatic logic [P_W-1:0] full_product(input logic [A_W-1:0] x,
			input logic [B_W-1:0] y);
		logic [P_W-1:0] xe;
		logic [P_W-1:0] ye;
		xe = P_W'(x);
		ye = P_W'(y);
		return xe * ye;
	endfunction

	function automatic logic [P_W-1:0] rand_wide();
		logic [P_W-1:0] v;
		v = '0;
		for (int i = 0; i < P_W; i += 32) begin
			v = (v << 32) | P_W'($unsigned($random(seed)));
		end
		return v;
	endfunction

	task automatic set_row(input int idx, input logic [A_W-1:0] ra,
			input logic [B_W-1:0] rb, input logic busy, input int gap);
		rows[idx].a = ra;
		rows[idx].b = rb;
		rows[idx].busy_start = busy;
		rows[idx].gap = 4'(gap);
	endtask

	task automatic fill_rows();
		set_row(0, '0, '0, 1'b0, 0);
		set_row(1, A_W'(1), B_W'(1), 1'b0, 2);
		set_row(2, '1, B_W'(1), 1'b0, 0);
		set_row(3, '0, '1, 1'b1, 0);
		set_row(4, '1, '1, 1'b1, 3);
		// Single high digits
		set_row(5, A_W'(64'h0123_4567_89ab_cdef), B_W'(9) << (B_W - D_W), 1'b0, 0);
		set_row(6, A_W'(15) << (A_W - D_W), B_W'(15) << (B_W - D_W), 1'b0, 4);
		set_row(7, A_W'(64'hdead_beef_0bad_f00d), B_W'(64'h0fed_cba9_8765_4321), 1'b1, 1);
		for (int i = 0; i < NUM_ROWS - NUM_DIRECTED; i++) begin
			set_row(NUM_DIRECTED + i, A_W'(rand_wide()), B_W'(rand_wide()), i[0], (i % 3) * 2);
		end
	endtask

	task automatic run_row(input int idx, input row_t row);
		logic [P_W-1:0] expected;
		logic [P_W-1:0] held;
		int             done_cycle;
		int             n;
		expected = full_product(row.a, row.b);
		done_cycle = 0;
		n = 0;
		@(posedge clk);
		start <= 1'b1;
		a <= row.a;
		b <= row.b;
		// Iteration n looks at run cycle n, counted from the accepting edge
		while (done_cycle == 0 && n < 2 * LATENCY) begin
			n++;
			@(posedge clk);
			if (n == 1) begin
				start <= 1'b0;
			end
			if (row.busy_start && n == DECOY_CYCLE) begin
				start <= 1'b1;
				a <= ~row.a;
				b <= ~row.b;
			end
			if (row.busy_start && n == DECOY_CYCLE + 1) begin
				start <= 1'b0;
			end
			@(negedge clk);
			checks++;
			if (status.done) begin
				done_cycle = n;
			end else if (!status.busy) begin
				$display("Error at time %0t: row %0d busy low in run cycle %0d", $time, idx, n);
				errors++;
			end
		end
		if (done_cycle == 0) begin
			$display("Row %0d: done never arrived within %0d cycles", idx, 2 * LATENCY);
			errors++;
		end else begin
			checks += 3;
			if (done_cycle != LATENCY) begin
				$display("Error at time %0t: row %0d done in cycle %0d, expected %0d",
					$time, idx, done_cycle, LATENCY);
				errors++;
			end
			if (status.busy) begin
				$display("Error at time %0t: row %0d busy high in the done cycle", $time, idx);
				errors++;
			end
			if (product !== expected) begin
				$display("Error at time %0t: row %0d product %h, expected %h",
					$time, idx, product, expected);
				errors++;
			end
		end
		// Result must hold while the inputs wander
		held = product;
		for (int g = 0; g < int'(row.gap); g++) begin
			@(posedge clk);
			a <= A_W'(rand_wide());
			b <= B_W'(rand_wide());
			@(negedge clk);
			checks++;
			if (product !== held || status.busy || status.done) begin
				$display("Error at time %0t: row %0d product %h changed after done, held %h",
					$time, idx, product, held);
				errors++;
			end
		end
	endtask

	initial begin
		int afails;
		seed = 32'h535f;
		errors = 0;
		checks = 0;
		rst = 1'b1;
		start = 1'b0;
		a = '0;
		b = '0;
		fill_rows();
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		// Quiet state before the first start
		repeat (3) begin
			@(negedge clk);
			checks++;
			if (status.busy || status.done || product !== '0) begin
				$display("Error at time %0t: idle after reset busy %b done %b product %h",
					$time, status.busy, status.done, product);
				errors++;
			end
		end
		for (int i = 0; i < NUM_ROWS; i++) begin
			run_row(i, rows[i]);
		end
		repeat (2) @(posedge clk);
		afails = dut0.seq0.props0.fail_cnt;
		$display("Summary: %0d checks, %0d errors, %0d assertion failures",
			checks, errors, afails);
		if (errors == 0 && afails == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// File: source/digit_mul_unit.sv
/*
 * Digit multiplier
 * Forms a_op times one digit by bit-serial shift-and-add
 */
`timescale 1ns/1ps

module digit_mul_unit
	import mul_types_pkg::*;
#(
	parameter int A_WIDTH     = 64,
	parameter int DIGIT_WIDTH = 4
) (
	input  logic                           clk,
	input  logic                           rst,
	input  digit_cmd_t                     cmd,
	input  logic [A_WIDTH-1:0]             a_op,
	input  logic [DIGIT_WIDTH-1:0]         digit,
	output logic [A_WIDTH+DIGIT_WIDTH-1:0] partial,
	output logic                           partial_valid
);

	localparam int SUM_W = A_WIDTH + DIGIT_WIDTH;
	localparam int CNT_W = (DIGIT_WIDTH > 1) ? $clog2(DIGIT_WIDTH) : 1;

	logic [SUM_W-1:0]       sum;
	logic [SUM_W-1:0]       a_ext;
	logic [DIGIT_WIDTH-1:0] digit_q;
	logic [CNT_W-1:0]       bit_cnt;
	logic                   active;

	assign a_ext = SUM_W'(a_op);

	// Sum register, one digit bit per cycle
	always_ff @(posedge clk) begin
		if (cmd.start) begin
			sum <= '0;
			digit_q <= digit;
		end else if (active && digit_q[bit_cnt]) begin
			sum <= sum + (a_ext << bit_cnt);
		end
	end

	// Bit counter and completion pulse
	always_ff @(posedge clk) begin
		if (rst) begin
			active <= 1'b0;
			bit_cnt <= '0;
			partial_valid <= 1'b0;
		end else begin
			partial_valid <= 1'b0;
			if (cmd.start) begin
				active <= 1'b1;
				bit_cnt <= '0;
			end else if (active) begin
				bit_cnt <= bit_cnt + 1'b1;
				// Last bit folds in on this edge, so the sum is final next cycle
				if (bit_cnt == CNT_W'(DIGIT_WIDTH - 1)) begin
					active <= 1'b0;
					partial_valid <= 1'b1;
				end
			end
		end
	end

	assign partial = sum;

endmodule

// File: source/digit_sequencer.sv
/*
 * Digit sequencer
 * Captures operands on start and walks b one digit at a time,
 * LSD first, issuing one command per partial product
 */
`timescale 1ns/1ps

module digit_sequencer
	import mul_cfg_pkg::*;
	import mul_types_pkg::*;
#(
	parameter int A_WIDTH     = 64,
	parameter int B_WIDTH     = 64,
	parameter int DIGIT_WIDTH = 4
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   start,
	input  logic [A_WIDTH-1:0]     a,
	input  logic [B_WIDTH-1:0]     b,
	output logic [A_WIDTH-1:0]     a_op,
	output logic [DIGIT_WIDTH-1:0] digit,
	output digit_cmd_t             cmd,
	input  logic                   partial_valid,
	output mul_status_t            status
);

	localparam int NUM_DIGITS = B_WIDTH / DIGIT_WIDTH;

	seq_state_t         state;
	logic [INDEX_W-1:0] index;
	logic [A_WIDTH-1:0] a_q;
	logic [B_WIDTH-1:0] b_q;
	logic               accept;
	logic               last_digit;

	// Start is taken whenever busy is low, including the done cycle
	assign accept = start && ((state == ST_IDLE) || (state == ST_FINISH));
	assign last_digit = (index == INDEX_W'(NUM_DIGITS - 1));

	// Operand capture
	always_ff @(posedge clk) begin
		if (accept) begin
			a_q <= a;
			b_q <= b;
		end
	end

	// Run control FSM
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			index <= '0;
		end else begin
			unique case (state)
				ST_IDLE: begin
					if (accept) begin
						index <= '0;
						state <= ST_ISSUE;
					end
				end
				ST_ISSUE: begin
					state <= ST_WAIT_PARTIAL;
				end
				ST_WAIT_PARTIAL: begin
					if (partial_valid) begin
						if (last_digit) begin
							state <= ST_FINISH;
						end else begin
							index <= index + 1'b1;
							state <= ST_ISSUE;
						end
					end
				end
				ST_FINISH: begin
					if (accept) begin
						index <= '0;
						state <= ST_ISSUE;
					end else begin
						state <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// Datapath feeds for the digit multiplier
	assign a_op = a_q;
	assign digit = b_q[index * DIGIT_WIDTH +: DIGIT_WIDTH];

	// One start per digit, clear only with the first one
	assign cmd.start = (state == ST_ISSUE);
	assign cmd.clear = (state == ST_ISSUE) && (index == '0);
	assign cmd.index = index;

	// Done lasts exactly the one finish cycle
	assign status.busy = (state == ST_ISSUE) || (state == ST_WAIT_PARTIAL);
	assign status.done = (state == ST_FINISH);

endmodule

// File: source/mul_cfg_pkg.sv
/*
 * Multiplier configuration defaults
 * Operand and digit widths used by the top level, plus index sizing
 */
package mul_cfg_pkg;

	// Operand widths
	parameter int A_WIDTH_DEF = 64;
	parameter int B_WIDTH_DEF = 64;

	// Digit of b consumed per partial product
	parameter int DIGIT_WIDTH_DEF = 4;

	// Digit index width, enough for 256 digits
	parameter int INDEX_W = 8;

endpackage

// File: source/mul_top.sv
/*
 * Digit-serial multiplier top level
 * Sequencer, digit multiplier and accumulator for unsigned a times b
 */
`timescale 1ns/1ps

module mul_top
	import mul_cfg_pkg::*;
	import mul_types_pkg::*;
#(
	parameter int A_WIDTH     = A_WIDTH_DEF,
	parameter int B_WIDTH     = B_WIDTH_DEF,
	parameter int DIGIT_WIDTH = DIGIT_WIDTH_DEF
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       start,
	input  logic [A_WIDTH-1:0]         a,
	input  logic [B_WIDTH-1:0]         b,
	output logic [A_WIDTH+B_WIDTH-1:0] product,
	output mul_status_t                status
);

	logic [A_WIDTH-1:0]             a_op;
	logic [DIGIT_WIDTH-1:0]         digit;
	digit_cmd_t                     cmd;
	logic [A_WIDTH+DIGIT_WIDTH-1:0] partial;
	logic                           partial_valid;

	digit_sequencer #(
		.A_WIDTH     (A_WIDTH),
		.B_WIDTH     (B_WIDTH),
		.DIGIT_WIDTH (DIGIT_WIDTH)
	) seq0 (
		.clk           (clk),
		.rst           (rst),
		.start         (start),
		.a             (a),
		.b             (b),
		.a_op          (a_op),
		.digit         (digit),
		.cmd           (cmd),
		.partial_valid (partial_valid),
		.status        (status)
	);

	digit_mul_unit #(
		.A_WIDTH     (A_WIDTH),
		.DIGIT_WIDTH (DIGIT_WIDTH)
	) mul0 (
		.clk           (clk),
		.rst           (rst),
		.cmd           (cmd),
		.a_op          (a_op),
		.digit         (digit),
		.partial       (partial),
		.partial_valid (partial_valid)
	);

	product_accumulator #(
		.A_WIDTH     (A_WIDTH),
		.B_WIDTH     (B_WIDTH),
		.DIGIT_WIDTH (DIGIT_WIDTH)
	) acc0 (
		.clk           (clk),
		.rst           (rst),
		.cmd           (cmd),
		.partial       (partial),
		.partial_valid (partial_valid),
		.product       (product)
	);

endmodule

// File: source/mul_types_pkg.sv
/*
 * Multiplier shared types
 * Sequencer states, per-digit command and top-level status
 */
package mul_types_pkg;
	import mul_cfg_pkg::*;

	// Run control states
	typedef enum logic [1:0] {
		ST_IDLE         = 2'd0,
		ST_ISSUE        = 2'd1,
		ST_WAIT_PARTIAL = 2'd2,
		ST_FINISH       = 2'd3
	} seq_state_t;

	// Per-digit command from the sequencer
	typedef struct packed {
		logic               start;
		logic               clear;
		logic [INDEX_W-1:0] index;
	} digit_cmd_t;

	// Run status seen from outside
	typedef struct packed {
		logic busy;
		logic done;
	} mul_status_t;

endpackage

// File: source/product_accumulator.sv
/*
 * Product accumulator
 * Adds each partial product into the result at its digit weight
 */
`timescale 1ns/1ps

module product_accumulator
	import mul_cfg_pkg::*;
	import mul_types_pkg::*;
#(
	parameter int A_WIDTH     = 64,
	parameter int B_WIDTH     = 64,
	parameter int DIGIT_WIDTH = 4
) (
	input  logic                           clk,
	input  logic                           rst,
	input  digit_cmd_t                     cmd,
	input  logic [A_WIDTH+DIGIT_WIDTH-1:0] partial,
	input  logic                           partial_valid,
	output logic [A_WIDTH+B_WIDTH-1:0]     product
);

	localparam int PROD_W = A_WIDTH + B_WIDTH;

	logic [INDEX_W-1:0] index_q;
	logic [PROD_W-1:0]  partial_ext;
	logic [PROD_W-1:0]  weighted;

	// Digit position held for the whole digit period
	always_ff @(posedge clk) begin
		if (cmd.start) begin
			index_q <= cmd.index;
		end
	end

	assign partial_ext = PROD_W'(partial);
	assign weighted = partial_ext << (index_q * DIGIT_WIDTH);

	// Result register, holds between runs
	always_ff @(posedge clk) begin
		if (rst) begin
			product <= '0;
		end else if (cmd.clear) begin
			product <= '0;
		end else if (partial_valid) begin
			product <= product + weighted;
		end
	end

endmodule
